// File: vlog.f
logic/axi_mem_cfg_pkg.sv
logic/axi_chan_pkg.sv
logic/bram_sdp.sv
logic/axi_wr_engine.sv
logic/axi_rd_engine.sv
logic/r_beat_fifo.sv
logic/axi_bram_responder.sv
sim/tb_clk_gen.sv
sim/tb_axi_bram_responder.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

log=sim_run.log

verilator --binary --timing -Wno-fatal -f vlog.f \
   --top-module tb_axi_bram_responder -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "all tests passed" "$log"; then
   echo "result: pass"
   exit 0
fi
echo "result: fail"
exit 1

// File: sim/tb_axi_bram_responder.sv
// testbench: stimulus, reference memory model, response monitor, watchdog

`timescale 1ns/1ps

module tb_axi_bram_responder
   import axi_mem_cfg_pkg::*;
   import axi_chan_pkg::*;
();

   localparam int CH_AW     = 0;  // channel selectors for wait_accept
   localparam int CH_W      = 1;
   localparam int CH_AR     = 2;
   localparam int WD_FILL   = 0;  // data = address pattern, all strobes
   localparam int WD_FULL   = 1;  // random data, all strobes
   localparam int WD_RANDOM = 2;  // random data, random strobes
   localparam int RUN_BEATS = 2**WORD_ADDR_W + 2 + 40 * 2 * MAX_BEATS + 3 * MAX_BEATS;
   localparam int WATCHDOG_CYCLES = RUN_BEATS * 40 + 2000;

   logic    clk;
   logic    reset_n;
   logic    aw_valid;
   aw_req_t aw;
   logic    aw_ready;
   logic    w_valid;
   w_beat_t w;
   logic    w_ready;
   logic    b_valid;
   b_rsp_t  b_rsp;
   logic    b_ready;
   logic    ar_valid;
   ar_req_t ar;
   logic    ar_ready;
   logic    r_valid;
   r_beat_t r_obs;
   logic    r_ready;

   data_t   model_mem [2**WORD_ADDR_W];  // reference copy of the memory
   r_beat_t exp_r [$];                   // read beats still owed
   b_rsp_t  exp_b [$];                   // write responses still owed
   r_beat_t r_exp;
   b_rsp_t  b_exp;
   b_rsp_t  b_prev;                      // b payload while stalled
   logic    b_pending;
   integer  seed;
   int      err_count;

   tb_clk_gen u_clk_gen (.o_clk(clk), .o_reset_n(reset_n));

   axi_bram_responder u_dut (
      .i_clk      (clk),      .i_reset_n  (reset_n),
      .i_aw_valid (aw_valid), .i_aw       (aw),      .o_aw_ready (aw_ready),
      .i_w_valid  (w_valid),  .i_w        (w),       .o_w_ready  (w_ready),
      .o_b_valid  (b_valid),  .o_b        (b_rsp),   .i_b_ready  (b_ready),
      .i_ar_valid (ar_valid), .i_ar       (ar),      .o_ar_ready (ar_ready),
      .o_r_valid  (r_valid),  .o_r        (r_obs),   .i_r_ready  (r_ready)
   );

   // -------------------------------------------------------------------
   // reference model
   // -------------------------------------------------------------------
   function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
      data_t res;
      res = old_word;
      for (int b = 0; b < STRB_W; b++)
      begin
         if (strb[b])
            res[8*b +: 8] = new_word[8*b +: 8];  // strobed byte replaced
      end
      return res;
   endfunction

   function automatic r_beat_t expected_beat(word_addr_t word, axi_id_t id, logic last);
      r_beat_t beat;
      beat.data = model_mem[word];
      beat.id   = id;
      beat.resp = RESP_OKAY;
      beat.last = last;
      return beat;
   endfunction

   function automatic data_t fill_word(word_addr_t word);
      return {word, 23'h1d2b4, ~word, 23'h4b2d1};  // whole index in both halves
   endfunction

   // -------------------------------------------------------------------
   // checking
   // -------------------------------------------------------------------
   task automatic stop_run();
      err_count++;
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [127:0] expected,
                              input logic [127:0] actual);
      if (actual !== expected)
      begin
         $display("Fail %s expected %0h actual %0h", name, expected, actual);
         stop_run();
      end
   endtask

   // sampled at the falling edge, half a cycle clear of both edges
   always @(negedge clk)
   begin
      if (reset_n)
      begin
         if (r_valid && r_ready)
         begin
            if (exp_r.size() == 0)
            begin
               $display("a read beat arrived while none was outstanding");
               stop_run();
            end
            r_exp = exp_r.pop_front();
            check_value("o_r.data", r_exp.data, r_obs.data);
            check_value("o_r.id", r_exp.id, r_obs.id);
            check_value("o_r.resp", r_exp.resp, r_obs.resp);
            check_value("o_r.last", r_exp.last, r_obs.last);
         end
         if (b_pending && !b_valid)
         begin
            $display("write response valid dropped before its handshake");
            stop_run();
         end
         if (b_valid)
         begin
            if (b_pending)
               check_value("o_b", b_prev, b_rsp);  // must hold while stalled
            if (b_ready)
            begin
               if (exp_b.size() == 0)
               begin
                  $display("a write response arrived with no write outstanding");
                  stop_run();
               end
               b_exp = exp_b.pop_front();
               check_value("o_b.id", b_exp.id, b_rsp.id);
               check_value("o_b.resp", b_exp.resp, b_rsp.resp);
               b_pending = 1'b0;
            end
            else
            begin
               b_pending = 1'b1;
               b_prev    = b_rsp;
            end
         end
      end
   end

   // -------------------------------------------------------------------
   // channel drivers, each starts and ends 2 ns after a rising edge
   // -------------------------------------------------------------------
   task automatic wait_accept(input int chan);
      logic hs;
      hs = 1'b0;
      while (!hs)
      begin
         @(negedge clk);
         case (chan)
            CH_AW:   hs = aw_ready;  // valid already high
            CH_W:    hs = w_ready;
            default: hs = ar_ready;
         endcase
         @(posedge clk);
         #2;
      end
   endtask

   task automatic write_burst(input axi_id_t id, input word_addr_t start,
                              input int beats, input int mode);
      word_addr_t word;
      data_t      data;
      strb_t      strb;
      int         hold;
      word     = start;
      aw_valid = 1'b1;
      aw       = '{id: id, addr: {start, 3'b000}, len: axi_len_t'(beats - 1)};
      exp_b.push_back('{id: id, resp: RESP_OKAY});
      wait_accept(CH_AW);
      aw_valid = 1'b0;
      for (int n = 0; n < beats; n++)
      begin
         data = {$random(seed), $random(seed)};
         strb = '1;
         if (mode == WD_FILL)
            data = fill_word(word);
         else if (mode == WD_RANDOM)
            strb = strb_t'($random(seed));
         w_valid = 1'b1;
         w       = '{data: data, strb: strb, last: (n == beats - 1)};
         wait_accept(CH_W);
         model_mem[word] = merge_bytes(model_mem[word], data, strb);
         word = word_addr_t'(word + 1);  // wraps mod 512
      end
      w_valid = 1'b0;
      hold    = int'($unsigned($random(seed)) % 11);  // b stall, 0 to 10 cycles
      do @(negedge clk); while (!b_valid);
      repeat (hold) @(negedge clk);
      @(posedge clk);
      #2;
      b_ready = 1'b1;
      @(negedge clk);  // handshake at the coming edge
      @(posedge clk);
      #2;
      b_ready = 1'b0;
   endtask

   task automatic read_burst(input axi_id_t id, input word_addr_t start,
                             input int beats, input logic stall);
      word_addr_t word;
      integer     rnd;
      word = start;
      for (int n = 0; n < beats; n++)
      begin
         exp_r.push_back(expected_beat(word, id, n == beats - 1));  // rlast on final beat
         word = word_addr_t'(word + 1);
      end
      ar_valid = 1'b1;
      ar       = '{id: id, addr: {start, 3'b000}, len: axi_len_t'(beats - 1)};
      wait_accept(CH_AR);
      ar_valid = 1'b0;
      while (exp_r.size() != 0)
      begin
         rnd     = $random(seed);
         r_ready = stall ? rnd[0] : 1'b1;  // low about half the time
         @(posedge clk);
         #2;
      end
      r_ready = 1'b1;
      repeat (6) @(posedge clk);  // room for a stray extra beat
      @(negedge clk);
      check_value("o_r_valid", 1'b0, r_valid);
      @(posedge clk);
      #2;
   endtask

   // -------------------------------------------------------------------
   // test sequence
   // -------------------------------------------------------------------
   initial
   begin
      axi_id_t    id;
      word_addr_t start;
      int         beats;
      integer     rnd;
      seed      = 37;
      err_count = 0;
      b_pending = 1'b0;
      aw_valid  = 1'b0;
      aw        = '0;
      w_valid   = 1'b0;
      w         = '0;
      b_ready   = 1'b0;
      ar_valid  = 1'b0;
      ar        = '0;
      r_ready   = 1'b1;
      repeat (8) @(negedge clk);
      check_value("o_b_valid", 1'b0, b_valid);  // inside reset
      check_value("o_r_valid", 1'b0, r_valid);
      wait (reset_n);
      @(negedge clk);
      check_value("o_b_valid", 1'b0, b_valid);  // just after release
      check_value("o_r_valid", 1'b0, r_valid);
      @(posedge clk);
      #2;

      // known contents everywhere first
      for (int blk = 0; blk < 2**WORD_ADDR_W / MAX_BEATS; blk++)
         write_burst(axi_id_t'(blk), word_addr_t'(blk * MAX_BEATS), MAX_BEATS, WD_FILL);

      write_burst(8'h5a, 9'd100, 1, WD_FULL);  // single beat
      read_burst(8'h5a, 9'd100, 1, 1'b0);

      for (int k = 0; k < 40; k++)
      begin
         rnd   = $random(seed);
         id    = rnd[7:0];
         rnd   = $random(seed);
         start = rnd[8:0];
         beats = 1 + int'($unsigned($random(seed)) % MAX_BEATS);
         write_burst(id, start, beats, WD_RANDOM);
         read_burst(axi_id_t'(id + 8'd1), start, beats, k[0]);  // r stalls on odd bursts
      end

      write_burst(8'hc3, 9'd508, MAX_BEATS, WD_FULL);  // runs past the top
      read_burst(8'h3c, 9'd0, 12, 1'b0);
      read_burst(8'h3d, 9'd508, MAX_BEATS, 1'b1);

      if (err_count == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

   // watchdog, 40 cycles per beat plus margin
   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
      stop_run();
   end

endmodule

// File: sim/tb_clk_gen.sv
// testbench clock and synchronous reset source

`timescale 1ns/1ps

module tb_clk_gen
(
   output logic o_clk,      // 40 ns period
   output logic o_reset_n   // low for the first cycles
);

   localparam int HALF_PERIOD  = 20;  // ns
   localparam int RESET_CYCLES = 16;

   initial
   begin
      o_clk = 1'b0;
      forever #HALF_PERIOD o_clk = ~o_clk;
   end

   initial
   begin
      o_reset_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge o_clk);
      #2;
      o_reset_n = 1'b1;  // released off the edge, like all stimulus
   end

endmodule

// File: logic/axi_bram_responder.sv
// top level: write engine, read engine, read beat fifo and block memory

`timescale 1ns/1ps

module axi_bram_responder
   import axi_mem_cfg_pkg::*;
   import axi_chan_pkg::*;
(
   input  logic    i_clk,
   input  logic    i_reset_n,   // sync, active low
   // aw channel
   input  logic    i_aw_valid,
   input  aw_req_t i_aw,
   output logic    o_aw_ready,
   // w channel
   input  logic    i_w_valid,
   input  w_beat_t i_w,
   output logic    o_w_ready,
   // b channel
   output logic    o_b_valid,
   output b_rsp_t  o_b,
   input  logic    i_b_ready,
   // ar channel
   input  logic    i_ar_valid,
   input  ar_req_t i_ar,
   output logic    o_ar_ready,
   // r channel
   output logic    o_r_valid,
   output r_beat_t o_r,
   input  logic    i_r_ready
);

   // -------------------------------------------------------------------
   // internal strobes
   // -------------------------------------------------------------------
   logic       wr_en;      // memory write port
   word_addr_t wr_addr;
   data_t      wr_data;
   strb_t      wr_strb;
   logic       rd_en;      // memory read port
   word_addr_t rd_addr;
   data_t      rd_data;
   logic       push;       // read engine to fifo
   r_beat_t    push_beat;
   logic       pop;        // fifo to read engine, credit

   axi_wr_engine u_wr_engine (
      .i_clk      (i_clk),      .i_reset_n  (i_reset_n),
      .i_aw_valid (i_aw_valid), .i_aw       (i_aw),      .o_aw_ready (o_aw_ready),
      .i_w_valid  (i_w_valid),  .i_w        (i_w),       .o_w_ready  (o_w_ready),
      .o_b_valid  (o_b_valid),  .o_b        (o_b),       .i_b_ready  (i_b_ready),
      .o_wr_en    (wr_en),      .o_wr_addr  (wr_addr),
      .o_wr_data  (wr_data),    .o_wr_strb  (wr_strb)
   );

   axi_rd_engine u_rd_engine (
      .i_clk       (i_clk),      .i_reset_n  (i_reset_n),
      .i_ar_valid  (i_ar_valid), .i_ar       (i_ar),      .o_ar_ready (o_ar_ready),
      .o_rd_en     (rd_en),      .o_rd_addr  (rd_addr),   .i_rd_data  (rd_data),
      .i_pop       (pop),        .o_push     (push),      .o_push_beat (push_beat)
   );

   r_beat_fifo u_r_fifo (
      .i_clk       (i_clk),      .i_reset_n  (i_reset_n),
      .i_push      (push),       .i_push_beat (push_beat),
      .o_r_valid   (o_r_valid),  .o_r        (o_r),       .i_r_ready  (i_r_ready),
      .o_pop       (pop)
   );

   bram_sdp u_mem (
      .i_clk     (i_clk),
      .i_wr_en   (wr_en),   .i_wr_addr (wr_addr),
      .i_wr_data (wr_data), .i_wr_strb (wr_strb),
      .i_rd_en   (rd_en),   .i_rd_addr (rd_addr),
      .o_rd_data (rd_data)
   );

endmodule

// File: logic/r_beat_fifo.sv
// read beat fifo, circular buffer that drives the r channel

`timescale 1ns/1ps

module r_beat_fifo
   import axi_mem_cfg_pkg::*;
   import axi_chan_pkg::*;
(
   input  logic    i_clk,
   input  logic    i_reset_n,    // sync, active low
   // from read engine
   input  logic    i_push,       // never while full, credit rule
   input  r_beat_t i_push_beat,
   // r channel
   output logic    o_r_valid,    // fifo not empty
   output r_beat_t o_r,          // head entry
   input  logic    i_r_ready,
   // back to read engine
   output logic    o_pop         // credit release
);

   r_beat_t                         buf_q [R_FIFO_DEPTH];  // beat storage
   logic [$clog2(R_FIFO_DEPTH)-1:0] wr_ptr;                // next free slot
   logic [$clog2(R_FIFO_DEPTH)-1:0] rd_ptr;                // head slot
   logic [$clog2(R_FIFO_DEPTH):0]   count;                 // entries held

   assign o_r_valid = (count != '0);
   assign o_r       = buf_q[rd_ptr];
   assign o_pop     = o_r_valid && i_r_ready;  // r handshake

   // -------------------------------------------------------------------
   // pointers and count
   // -------------------------------------------------------------------
   always_ff @(posedge i_clk)
   begin
      if (!i_reset_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (i_push)
            wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
         if (o_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({i_push, o_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // idle or push with pop
         endcase
      end
   end

   // storage write
   always_ff @(posedge i_clk)
   begin
      if (i_push)
         buf_q[wr_ptr] <= i_push_beat;
   end

endmodule

// File: logic/axi_rd_engine.sv
// read engine fsm: ar capture, credit-limited memory reads, tag pipeline

`timescale 1ns/1ps

module axi_rd_engine
   import axi_mem_cfg_pkg::*;
   import axi_chan_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_reset_n,    // sync, active low
   // ar channel
   input  logic       i_ar_valid,
   input  ar_req_t    i_ar,
   output logic       o_ar_ready,   // high only in RD_IDLE
   // memory read port
   output logic       o_rd_en,
   output word_addr_t o_rd_addr,
   input  data_t      i_rd_data,
   // beat fifo side
   input  logic       i_pop,        // one r handshake
   output logic       o_push,       // memory data is valid
   output r_beat_t    o_push_beat
);

   typedef enum logic {
      RD_IDLE,   // wait for ar
      RD_ISSUE   // one read per cycle while credit lasts
   } rd_state_e;

   rd_state_e                     state;
   rd_state_e                     state_nxt;
   logic                          ar_hs;      // ar handshake
   logic                          issue;      // memory read this cycle
   logic                          issue_last; // issuing beat number len
   axi_id_t                       rd_id;      // captured ar id
   word_addr_t                    rd_word;    // next word to read
   logic [$clog2(MAX_BEATS)-1:0]  beat_cnt;   // beats issued so far
   logic [$clog2(MAX_BEATS)-1:0]  last_beat;  // len, max 15
   logic [$clog2(R_FIFO_DEPTH):0] credit;     // in pipe plus in fifo
   logic [RD_LATENCY-1:0]         tag_vld;    // beat in each stage
   logic [RD_LATENCY-1:0]         tag_last;   // rlast per stage
   axi_id_t                       tag_id [RD_LATENCY];

   assign ar_hs      = i_ar_valid && o_ar_ready;
   assign issue      = (state == RD_ISSUE) && (credit < R_FIFO_DEPTH);
   assign issue_last = issue && (beat_cnt == last_beat);

   // -------------------------------------------------------------------
   // state machine
   // -------------------------------------------------------------------
   always_comb
   begin
      state_nxt = state;
      case (state)
         RD_IDLE:  if (ar_hs) state_nxt = RD_ISSUE;
         RD_ISSUE: if (issue_last) state_nxt = RD_IDLE;  // earlier beats may still fly
         default:  state_nxt = RD_IDLE;
      endcase
   end

   always_ff @(posedge i_clk)
   begin
      if (!i_reset_n)
      begin
         state      <= RD_IDLE;
         o_ar_ready <= 1'b0;  // low during reset
         tag_vld    <= '0;
         credit     <= '0;
      end
      else
      begin
         state      <= state_nxt;
         o_ar_ready <= (state_nxt == RD_IDLE);
         tag_vld    <= {tag_vld[RD_LATENCY-2:0], issue};
         case ({issue, i_pop})
            2'b10:   credit <= credit + 1'b1;  // beat issued
            2'b01:   credit <= credit - 1'b1;  // beat left on r
            default: credit <= credit;         // none or both
         endcase
      end
   end

   // -------------------------------------------------------------------
   // burst counters, word address, tags
   // -------------------------------------------------------------------
   always_ff @(posedge i_clk)
   begin
      if (ar_hs)
      begin
         rd_id     <= i_ar.id;
         rd_word   <= i_ar.addr[BYTE_OFS_W +: WORD_ADDR_W];
         last_beat <= i_ar.len[$clog2(MAX_BEATS)-1:0];
         beat_cnt  <= '0;
      end
      else if (issue)
      begin
         rd_word  <= rd_word + 1'b1;  // wraps mod 512
         beat_cnt <= beat_cnt + 1'b1;
      end
   end

   always_ff @(posedge i_clk)
   begin
      tag_id[0]   <= rd_id;
      tag_last[0] <= issue_last;
      for (int s = 1; s < RD_LATENCY; s++)
      begin
         tag_id[s]   <= tag_id[s-1];    // follows the memory pipe
         tag_last[s] <= tag_last[s-1];
      end
   end

   assign o_rd_en   = issue;
   assign o_rd_addr = rd_word;

   // tags meet data at the end of the pipe
   assign o_push      = tag_vld[RD_LATENCY-1];
   assign o_push_beat = '{data: i_rd_data,
                          id:   tag_id[RD_LATENCY-1],
                          resp: RESP_OKAY,
                          last: tag_last[RD_LATENCY-1]};

endmodule

// File: logic/axi_wr_engine.sv
// write engine fsm: aw capture, w beats onto the memory port, b response

`timescale 1ns/1ps

module axi_wr_engine
   import axi_mem_cfg_pkg::*;
   import axi_chan_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_reset_n,   // sync, active low
   // aw channel
   input  logic       i_aw_valid,
   input  aw_req_t    i_aw,
   output logic       o_aw_ready,  // high only in WR_IDLE
   // w channel
   input  logic       i_w_valid,
   input  w_beat_t    i_w,
   output logic       o_w_ready,   // high only in WR_DATA
   // b channel
   output logic       o_b_valid,   // high only in WR_RSP
   output b_rsp_t     o_b,
   input  logic       i_b_ready,
   // memory write port
   output logic       o_wr_en,
   output word_addr_t o_wr_addr,
   output data_t      o_wr_data,
   output strb_t      o_wr_strb
);

   typedef enum logic [1:0] {
      WR_IDLE,  // wait for aw
      WR_DATA,  // take w beats until last
      WR_RSP    // hold b until accepted
   } wr_state_e;

   wr_state_e  state;
   wr_state_e  state_nxt;
   logic       aw_hs;    // aw handshake
   logic       w_hs;     // w handshake
   logic       b_hs;     // b handshake
   axi_id_t    b_id;     // captured aw id
   word_addr_t wr_word;  // next word to write

   assign aw_hs = i_aw_valid && o_aw_ready;
   assign w_hs  = i_w_valid && o_w_ready;
   assign b_hs  = o_b_valid && i_b_ready;

   // -------------------------------------------------------------------
   // state machine
   // -------------------------------------------------------------------
   always_comb
   begin
      state_nxt = state;
      case (state)
         WR_IDLE: if (aw_hs) state_nxt = WR_DATA;
         WR_DATA: if (w_hs && i_w.last) state_nxt = WR_RSP;  // burst ends on wlast
         WR_RSP:  if (b_hs) state_nxt = WR_IDLE;
         default: state_nxt = WR_IDLE;
      endcase
   end

   // ready/valid registered from next state so they line up with it
   always_ff @(posedge i_clk)
   begin
      if (!i_reset_n)
      begin
         state      <= WR_IDLE;
         o_aw_ready <= 1'b0;  // all low during reset
         o_w_ready  <= 1'b0;
         o_b_valid  <= 1'b0;
      end
      else
      begin
         state      <= state_nxt;
         o_aw_ready <= (state_nxt == WR_IDLE);
         o_w_ready  <= (state_nxt == WR_DATA);
         o_b_valid  <= (state_nxt == WR_RSP);
      end
   end

   // -------------------------------------------------------------------
   // address capture and memory write port
   // -------------------------------------------------------------------
   always_ff @(posedge i_clk)
   begin
      if (aw_hs)
      begin
         b_id    <= i_aw.id;
         wr_word <= i_aw.addr[BYTE_OFS_W +: WORD_ADDR_W];  // byte addr to word
      end
      else if (w_hs)
         wr_word <= wr_word + 1'b1;  // wraps mod 512
   end

   always_ff @(posedge i_clk)
   begin
      if (!i_reset_n)
         o_wr_en <= 1'b0;
      else
         o_wr_en <= w_hs;  // one write per accepted beat
   end

   always_ff @(posedge i_clk)
   begin
      if (w_hs)
      begin
         o_wr_addr <= wr_word;
         o_wr_data <= i_w.data;
         o_wr_strb <= i_w.strb;
      end
   end

   assign o_b = '{id: b_id, resp: RESP_OKAY};  // stable while in WR_RSP

endmodule

// File: logic/bram_sdp.sv
// simple dual-port memory, byte write enables, two-stage registered read

`timescale 1ns/1ps

module bram_sdp
   import axi_mem_cfg_pkg::*;
(
   input  logic       i_clk,
   // write port
   input  logic       i_wr_en,    // write strobe
   input  word_addr_t i_wr_addr,  // word index
   input  data_t      i_wr_data,  // write word
   input  strb_t      i_wr_strb,  // per-byte enable
   // read port
   input  logic       i_rd_en,    // read strobe
   input  word_addr_t i_rd_addr,  // word index
   output data_t      o_rd_data   // RD_LATENCY cycles after i_rd_en
);

   data_t      mem [2**WORD_ADDR_W];  // 512 words
   word_addr_t rd_addr_q;             // first read stage

   // -------------------------------------------------------------------
   // write port
   // -------------------------------------------------------------------
   always_ff @(posedge i_clk)
   begin
      for (int b = 0; b < STRB_W; b++)
      begin
         if (i_wr_en && i_wr_strb[b])  // unstrobed bytes keep old value
            mem[i_wr_addr][8*b +: 8] <= i_wr_data[8*b +: 8];
      end
   end

   // -------------------------------------------------------------------
   // read port
   // -------------------------------------------------------------------
   always_ff @(posedge i_clk)
   begin
      if (i_rd_en)
         rd_addr_q <= i_rd_addr;  // address register stage
   end

   // output register, holds while address holds
   always_ff @(posedge i_clk)
   begin
      o_rd_data <= mem[rd_addr_q];  // output register stage
   end

endmodule

// File: logic/axi_chan_pkg.sv
// packed payload structs for the aw, w, b, ar and r channels

package axi_chan_pkg;

   import axi_mem_cfg_pkg::*;

   // -------------------------------------------------------------------
   // write side
   // -------------------------------------------------------------------

   // write address, 28 bits
   typedef struct packed {
      axi_id_t   id;    // echoed on b
      axi_addr_t addr;  // starting byte address
      axi_len_t  len;   // beats minus one
   } aw_req_t;

   // write data beat, 73 bits
   typedef struct packed {
      data_t data;  // payload
      strb_t strb;  // byte enables
      logic  last;  // final beat of burst
   } w_beat_t;

   // write response, 10 bits
   typedef struct packed {
      axi_id_t id;    // copy of aw id
      resp_t   resp;  // always okay
   } b_rsp_t;

   // -------------------------------------------------------------------
   // read side
   // -------------------------------------------------------------------

   // read address, 28 bits, same layout as aw
   typedef struct packed {
      axi_id_t   id;    // echoed on every r beat
      axi_addr_t addr;  // starting byte address
      axi_len_t  len;   // beats minus one
   } ar_req_t;

   // read data beat, 75 bits
   typedef struct packed {
      data_t   data;  // memory word
      axi_id_t id;    // copy of ar id
      resp_t   resp;  // always okay
      logic    last;  // final beat of burst
   } r_beat_t;

endpackage

// File: logic/axi_mem_cfg_pkg.sv
// memory geometry, axi field widths and the vector types built on them

package axi_mem_cfg_pkg;

   // -------------------------------------------------------------------
   // geometry and field widths
   // -------------------------------------------------------------------
   localparam int DATA_W       = 64;  // data bus width
   localparam int STRB_W       = 8;   // one strobe per byte
   localparam int WORD_ADDR_W  = 9;   // 512 words deep
   localparam int AXI_ADDR_W   = 12;  // byte address
   localparam int ID_W         = 8;   // transaction id
   localparam int LEN_W        = 8;   // axi len field
   localparam int MAX_BEATS    = 16;  // longest burst
   localparam int RD_LATENCY   = 2;   // addr reg + out reg
   localparam int R_FIFO_DEPTH = 4;   // read beat fifo entries
   localparam int BYTE_OFS_W   = 3;   // byte bits under a word

   // -------------------------------------------------------------------
   // vector types
   // -------------------------------------------------------------------
   typedef logic [DATA_W-1:0]      data_t;       // one memory word
   typedef logic [STRB_W-1:0]      strb_t;       // byte enables
   typedef logic [WORD_ADDR_W-1:0] word_addr_t;  // word index
   typedef logic [AXI_ADDR_W-1:0]  axi_addr_t;   // byte address
   typedef logic [ID_W-1:0]        axi_id_t;     // aw/ar id
   typedef logic [LEN_W-1:0]       axi_len_t;    // beats minus one
   typedef logic [1:0]             resp_t;       // b/r response code

   localparam resp_t RESP_OKAY = 2'b00;  // only response ever returned

endpackage
